// File: all.f
+incdir+include
src/mac_ops_pkg.sv
src/mac_lane_pkg.sv
src/mac_issue.sv
src/mac_lane.sv
src/mac_collect.sv
src/mac_unit.sv
tests/mac_unit_tb.sv

// File: include/mac_consts.svh
//----------------------------
// Sizing constants for the MAC block
//----------------------------
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// Number of accumulator lanes
// Keep to a power of two (2, 4 or 8)
`define MAC_LANES       4

// Operand and result width
`define MAC_WIDTH       32    // Accumulator is twice this

// Queue slots per lane
`define MAC_LANE_DEPTH  2     // Also the issue credits per lane

// Credits granted by the consumer at reset
`define MAC_OUT_CREDITS 4

`endif

// File: run.sh
#!/bin/sh
# Build and run the MAC block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mac_unit_tb -f all.f -o mac_sim

./obj_dir/mac_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: src/mac_collect.sv
//----------------------------
// Round-robin result collector with output credits
//----------------------------
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_collect (
    input  logic                                   Clock,
    input  logic                                   nReset,
    input  logic [`MAC_LANES-1:0]                  ResValid,
    input  logic [`MAC_LANES-1:0][`MAC_WIDTH-1:0]  ResData,
    input  mac_lane_pkg::accFlags [`MAC_LANES-1:0] ResFlags,
    output logic [`MAC_LANES-1:0]                  ResTake,
    output logic                                   OutValid,
    output logic [$clog2(`MAC_LANES)-1:0]          OutLane,
    output logic [`MAC_WIDTH-1:0]                  OutData,
    output mac_lane_pkg::accFlags                  OutFlags,
    input  logic                                   OutCreditReturn
);

    localparam int laneBits   = $clog2(`MAC_LANES);
    localparam int creditBits = $clog2(`MAC_OUT_CREDITS + 1);

    logic [laneBits-1:0]   rrPtr;    // First lane to look at
    logic [laneBits-1:0]   pick;
    logic                  found;
    logic                  take;
    logic [creditBits-1:0] credits;  // Free entries at the consumer

    // Scan lanes starting at the pointer, wrapping at the lane count
    always_comb
    begin
        logic [laneBits-1:0] idx;
        pick  = rrPtr;
        found = 1'b0;
        for (int k = 0; k < `MAC_LANES; k++)
        begin
            idx = rrPtr + laneBits'(k);
            if (!found && ResValid[idx])
            begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    assign take = found && (credits != '0);

    always_comb
    begin
        ResTake = '0;
        if (take)
            ResTake[pick] = 1'b1;  // Doubles as the lane's credit return
    end

    //----------------------------
    // Output register and counters
    //----------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            OutValid <= 1'b0;
            rrPtr    <= '0;
            credits  <= creditBits'(`MAC_OUT_CREDITS);
        end
        else
        begin
            OutValid <= take;
            if (take)
                rrPtr <= pick + 1'b1;  // Winner goes to the back
            credits <= credits - creditBits'(take) + creditBits'(OutCreditReturn);
        end
    end

    always_ff @(posedge Clock)
    begin
        if (take)
        begin
            OutLane  <= pick;
            OutData  <= ResData[pick];
            OutFlags <= ResFlags[pick];
        end
    end

    // Consumer returns never outrun sends, so no pulse goes out unbacked
    assert property (@(posedge Clock) disable iff (!nReset)
        credits <= creditBits'(`MAC_OUT_CREDITS))
        else $error("Collector credit counter above the consumer's credit count");

endmodule

// File: src/mac_issue.sv
//----------------------------
// Issue stage with per-lane credit counters
//----------------------------
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_issue (
    input  logic                          Clock,
    input  logic                          nReset,
    input  logic                          InValid,
    input  logic [$clog2(`MAC_LANES)-1:0] InLane,
    input  mac_ops_pkg::macOp             InOp,
    input  logic [`MAC_WIDTH-1:0]         InA,
    input  logic [`MAC_WIDTH-1:0]         InB,
    output logic                          InReady,
    output logic [`MAC_LANES-1:0]         LaneValid,
    output mac_ops_pkg::macOp             LaneOp,
    output logic [`MAC_WIDTH-1:0]         LaneA,
    output logic [`MAC_WIDTH-1:0]         LaneB,
    input  logic [`MAC_LANES-1:0]         CreditReturn
);

    localparam int creditBits = $clog2(`MAC_LANE_DEPTH + 1);

    logic [creditBits-1:0] credit [`MAC_LANES];  // Free slots per lane
    logic                  accept;
    logic [`MAC_LANES-1:0] sendMask;             // One-hot target of this transfer

    // Ready only when the addressed lane has room
    assign InReady = (credit[InLane] != '0);
    assign accept  = InValid && InReady;

    always_comb
    begin
        sendMask = '0;
        if (accept)
            sendMask[InLane] = 1'b1;
    end

    //----------------------------
    // Credit counters and lane strobes
    //----------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            LaneValid <= '0;
            for (int i = 0; i < `MAC_LANES; i++)
                credit[i] <= creditBits'(`MAC_LANE_DEPTH);  // Every slot free
        end
        else
        begin
            LaneValid <= sendMask;  // Single-cycle pulse
            for (int i = 0; i < `MAC_LANES; i++)
                credit[i] <= credit[i] - creditBits'(sendMask[i])
                             + creditBits'(CreditReturn[i]);
        end
    end

    // Operation payload shared by all lanes
    always_ff @(posedge Clock)
    begin
        if (accept)
        begin
            LaneOp <= InOp;
            LaneA  <= InA;
            LaneB  <= InB;
        end
    end

    // Lane returns must never outrun sends
    for (genvar g = 0; g < `MAC_LANES; g++)
    begin : gCreditCheck
        assert property (@(posedge Clock) disable iff (!nReset)
            credit[g] <= creditBits'(`MAC_LANE_DEPTH))
            else $error("Issue credit counter of lane %0d out of range", g);
    end

endmodule

// File: src/mac_lane.sv
//----------------------------
// One MAC lane with queue, multiplier, accumulator
//----------------------------
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_lane (
    input  logic                  Clock,
    input  logic                  nReset,
    input  logic                  LaneValid,
    input  mac_ops_pkg::macOp     LaneOp,
    input  logic [`MAC_WIDTH-1:0] LaneA,
    input  logic [`MAC_WIDTH-1:0] LaneB,
    output logic                  ResValid,
    output logic [`MAC_WIDTH-1:0] ResData,
    output mac_lane_pkg::accFlags ResFlags,
    input  logic                  ResTake
);

    localparam int ptrBits   = $clog2(`MAC_LANE_DEPTH);
    localparam int countBits = $clog2(`MAC_LANE_DEPTH + 1);
    localparam int accBits   = 2 * `MAC_WIDTH;

    // Operation queue
    mac_ops_pkg::macOp     qOp [`MAC_LANE_DEPTH];
    logic [`MAC_WIDTH-1:0] qA  [`MAC_LANE_DEPTH];
    logic [`MAC_WIDTH-1:0] qB  [`MAC_LANE_DEPTH];
    logic [ptrBits-1:0]    wrPtr, rdPtr;
    logic [countBits-1:0]  qCount;
    logic                  qRead;
    logic                  headSigned;

    // Multiply slot
    mac_lane_pkg::laneStage      mulSlot;
    mac_ops_pkg::macOp           mulOp;
    logic signed [`MAC_WIDTH:0]  mulA, mulB;   // 33-bit extended operands
    logic signed [accBits+1:0]   mulProd;

    // Accumulate slot
    mac_lane_pkg::laneStage      accSlot;
    mac_ops_pkg::macOp           accOp;
    logic [accBits-1:0]          accProd;
    logic [`MAC_WIDTH-1:0]       accIn;        // Raw A for MTHI and MTLO
    logic [accBits-1:0]          acc, accNext;
    logic [`MAC_WIDTH-1:0]       resNext;
    logic                        carry, ovf;
    mac_lane_pkg::accFlags       flagsNext;

    // Advance controls
    logic resFree, accDone, accFree, mulMove, mulFree;

    assign resFree = !ResValid || ResTake;  // Result register empties this cycle
    assign accDone = (accSlot == mac_lane_pkg::stageAcc) && resFree;
    assign accFree = (accSlot == mac_lane_pkg::stageEmpty) || accDone;
    assign mulMove = (mulSlot == mac_lane_pkg::stageMul) && accFree;
    assign mulFree = (mulSlot == mac_lane_pkg::stageEmpty) || mulMove;
    assign qRead   = (qCount != '0) && mulFree;

    assign headSigned = qOp[rdPtr] inside {mac_ops_pkg::opMult, mac_ops_pkg::opMadd,
                                           mac_ops_pkg::opMsub};
    assign mulProd    = mulA * mulB;

    //----------------------------
    // Queue
    //----------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            qCount <= '0;
        end
        else
        begin
            if (LaneValid)
                wrPtr <= (wrPtr == ptrBits'(`MAC_LANE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (qRead)
                rdPtr <= (rdPtr == ptrBits'(`MAC_LANE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            qCount <= qCount + countBits'(LaneValid) - countBits'(qRead);
        end
    end

    always_ff @(posedge Clock)
    begin
        if (LaneValid)
        begin
            qOp[wrPtr] <= LaneOp;
            qA[wrPtr]  <= LaneA;
            qB[wrPtr]  <= LaneB;
        end
    end

    //----------------------------
    // Pipeline slots
    //----------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            mulSlot  <= mac_lane_pkg::stageEmpty;
            accSlot  <= mac_lane_pkg::stageEmpty;
            ResValid <= 1'b0;
            acc      <= '0;
        end
        else
        begin
            if (qRead)
                mulSlot <= mac_lane_pkg::stageMul;
            else if (mulMove)
                mulSlot <= mac_lane_pkg::stageEmpty;
            if (mulMove)
                accSlot <= mac_lane_pkg::stageAcc;
            else if (accDone)
                accSlot <= mac_lane_pkg::stageEmpty;
            if (accDone)
            begin
                ResValid <= 1'b1;
                acc      <= accNext;
            end
            else if (ResTake)
                ResValid <= 1'b0;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (qRead)
        begin
            mulOp <= qOp[rdPtr];
            mulA  <= {headSigned & qA[rdPtr][`MAC_WIDTH-1], qA[rdPtr]};  // Sign or zero
            mulB  <= {headSigned & qB[rdPtr][`MAC_WIDTH-1], qB[rdPtr]};
        end
        if (mulMove)
        begin
            accOp   <= mulOp;
            accProd <= mulProd[accBits-1:0];  // Low 64 bits are exact
            accIn   <= mulA[`MAC_WIDTH-1:0];
        end
        if (accDone)
        begin
            ResData  <= resNext;
            ResFlags <= flagsNext;
        end
    end

    //----------------------------
    // Accumulator update and flags
    //----------------------------
    always_comb
    begin
        accNext = acc;
        carry   = 1'b0;
        ovf     = 1'b0;
        case (accOp)
            mac_ops_pkg::opMult,
            mac_ops_pkg::opMultu:
                accNext = accProd;
            mac_ops_pkg::opMadd:
            begin
                {carry, accNext} = {1'b0, acc} + {1'b0, accProd};
                ovf = (acc[accBits-1] == accProd[accBits-1])
                      && (accNext[accBits-1] != acc[accBits-1]);
            end
            mac_ops_pkg::opMaddu:
            begin
                {carry, accNext} = {1'b0, acc} + {1'b0, accProd};
                ovf = carry;
            end
            mac_ops_pkg::opMsub:
            begin
                {carry, accNext} = {1'b0, acc} - {1'b0, accProd};  // Borrow out
                ovf = (acc[accBits-1] != accProd[accBits-1])
                      && (accNext[accBits-1] != acc[accBits-1]);
            end
            mac_ops_pkg::opMsubu:
            begin
                {carry, accNext} = {1'b0, acc} - {1'b0, accProd};
                ovf = carry;
            end
            mac_ops_pkg::opMthi: accNext[accBits-1:`MAC_WIDTH] = accIn;
            mac_ops_pkg::opMtlo: accNext[`MAC_WIDTH-1:0]       = accIn;
            default: ;  // MFHI and MFLO leave Acc alone
        endcase
    end

    // MFLO reads the unchanged low half like every other op
    assign resNext   = (accOp == mac_ops_pkg::opMfhi) ? acc[accBits-1:`MAC_WIDTH]
                                                     : accNext[`MAC_WIDTH-1:0];
    assign flagsNext = {carry, (accNext == '0), ovf, accNext[accBits-1]};

    // Issue credits keep the queue from overflowing
    assert property (@(posedge Clock) disable iff (!nReset)
        LaneValid |-> (qCount != countBits'(`MAC_LANE_DEPTH)))
        else $error("Lane queue written while full");

    // Result held until the collector takes it
    assert property (@(posedge Clock) disable iff (!nReset)
        (ResValid && !ResTake) |=> (ResValid && $stable(ResData) && $stable(ResFlags)))
        else $error("Lane result changed before it was taken");

endmodule

// File: src/mac_lane_pkg.sv
//----------------------------
// Lane slot states and result flag type
//----------------------------
package mac_lane_pkg;

    // State of one pipeline slot inside a lane
    typedef enum logic [1:0] {
        stageEmpty = 2'd0,  // Slot holds nothing
        stageMul   = 2'd1,  // Operands at the multiplier
        stageAcc   = 2'd2   // Product at the accumulator
    } laneStage;

    // Result flags packed as {C, Z, O, N}
    typedef logic [3:0] accFlags;

endpackage

// File: src/mac_ops_pkg.sv
//----------------------------
// Operation encoding for the MAC issue side
//----------------------------
package mac_ops_pkg;

    // Ten accumulator operations in 4 bits
    typedef enum logic [3:0] {
        opMult  = 4'd0,  // Signed product into Acc
        opMultu = 4'd1,  // Unsigned product into Acc
        opMadd  = 4'd2,  // Acc plus signed product
        opMaddu = 4'd3,  // Acc plus unsigned product
        opMsub  = 4'd4,  // Acc minus signed product
        opMsubu = 4'd5,  // Acc minus unsigned product
        opMthi  = 4'd6,  // Write high half
        opMtlo  = 4'd7,  // Write low half
        opMfhi  = 4'd8,  // Read high half
        opMflo  = 4'd9   // Read low half
    } macOp;

    // Codes 10 to 15 unused

endpackage

// File: src/mac_unit.sv
//----------------------------
// MAC block top with issue, lanes, collector
//----------------------------
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_unit (
    input  logic                          Clock,
    input  logic                          nReset,
    input  logic                          InValid,
    input  logic [$clog2(`MAC_LANES)-1:0] InLane,
    input  mac_ops_pkg::macOp             InOp,
    input  logic [`MAC_WIDTH-1:0]         InA,
    input  logic [`MAC_WIDTH-1:0]         InB,
    output logic                          InReady,
    output logic                          OutValid,
    output logic [$clog2(`MAC_LANES)-1:0] OutLane,
    output logic [`MAC_WIDTH-1:0]         OutData,
    output mac_lane_pkg::accFlags         OutFlags,
    input  logic                          OutCreditReturn
);

    // Issue to lanes
    logic [`MAC_LANES-1:0]                  laneValid;
    mac_ops_pkg::macOp                      laneOp;
    logic [`MAC_WIDTH-1:0]                  laneA, laneB;

    // Lanes to collector
    logic [`MAC_LANES-1:0]                  resValid;
    logic [`MAC_LANES-1:0][`MAC_WIDTH-1:0]  resData;
    mac_lane_pkg::accFlags [`MAC_LANES-1:0] resFlags;
    logic [`MAC_LANES-1:0]                  resTake;  // Also the issue credit return

    mac_issue uIssue (
        .Clock(Clock), .nReset(nReset),
        .InValid(InValid), .InLane(InLane), .InOp(InOp), .InA(InA), .InB(InB),
        .InReady(InReady),
        .LaneValid(laneValid), .LaneOp(laneOp), .LaneA(laneA), .LaneB(laneB),
        .CreditReturn(resTake)
    );

    for (genvar g = 0; g < `MAC_LANES; g++)
    begin : gLane
        mac_lane uLane (
            .Clock(Clock), .nReset(nReset),
            .LaneValid(laneValid[g]), .LaneOp(laneOp), .LaneA(laneA), .LaneB(laneB),
            .ResValid(resValid[g]), .ResData(resData[g]), .ResFlags(resFlags[g]),
            .ResTake(resTake[g])
        );
    end

    mac_collect uCollect (
        .Clock(Clock), .nReset(nReset),
        .ResValid(resValid), .ResData(resData), .ResFlags(resFlags), .ResTake(resTake),
        .OutValid(OutValid), .OutLane(OutLane), .OutData(OutData), .OutFlags(OutFlags),
        .OutCreditReturn(OutCreditReturn)
    );

endmodule

// File: tests/mac_unit_tb.sv
//----------------------------
// Testbench for the MAC block: stimulus, reference model, assertions
//----------------------------
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_unit_tb;

    localparam int laneBits    = $clog2(`MAC_LANES);
    localparam int entryBits   = laneBits + 36;  // {lane, flags, data}
    localparam int numRandom   = 300;
    localparam int numDirected = 40;             // Upper bound on directed ops
    localparam int numOps      = numDirected + numRandom;

    logic                  Clock;
    logic                  nReset;
    logic                  InValid;
    logic [laneBits-1:0]   InLane;
    mac_ops_pkg::macOp     InOp;
    logic [`MAC_WIDTH-1:0] InA, InB;
    logic                  InReady;
    logic                  OutValid;
    logic [laneBits-1:0]   OutLane;
    logic [`MAC_WIDTH-1:0] OutData;
    mac_lane_pkg::accFlags OutFlags;
    logic                  OutCreditReturn;

    // Reference model state
    logic [63:0]           modelAcc [`MAC_LANES];
    logic [entryBits-1:0]  pending [$];          // Expected results in issue order
    int                    inFlight [`MAC_LANES];
    int                    owed;                 // Results held by the consumer
    logic                  holdCredits;
    logic                  randomGaps;
    logic [31:0]           seed;
    int                    errors;
    string                 testName;

    // Expected head for the lane now on the output
    logic                  expPresent;
    logic [`MAC_WIDTH-1:0] expData;
    mac_lane_pkg::accFlags expFlags;

    mac_unit uut (
        .Clock(Clock), .nReset(nReset),
        .InValid(InValid), .InLane(InLane), .InOp(InOp), .InA(InA), .InB(InB),
        .InReady(InReady),
        .OutValid(OutValid), .OutLane(OutLane), .OutData(OutData), .OutFlags(OutFlags),
        .OutCreditReturn(OutCreditReturn)
    );

    initial
    begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;  // 4 ns period
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    //----------------------------
    // Reference model
    //----------------------------
    task automatic predict(input int lane, input mac_ops_pkg::macOp op,
                           input logic [31:0] a, input logic [31:0] b);
        logic [63:0] oldAcc;
        logic [63:0] p;
        logic [63:0] newAcc;
        logic [31:0] res;
        logic        c;
        logic        o;
        oldAcc = modelAcc[lane];
        newAcc = oldAcc;
        c      = 1'b0;
        o      = 1'b0;
        if (op inside {mac_ops_pkg::opMult, mac_ops_pkg::opMadd, mac_ops_pkg::opMsub})
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // Low 64 bits of signed product
        else
            p = {32'b0, a} * {32'b0, b};
        case (op)
            mac_ops_pkg::opMult, mac_ops_pkg::opMultu: newAcc = p;
            mac_ops_pkg::opMadd, mac_ops_pkg::opMaddu:
            begin
                newAcc = oldAcc + p;
                c = newAcc < oldAcc;  // Wrapped means carry out
                if (op == mac_ops_pkg::opMadd)
                    o = (oldAcc[63] == p[63]) && (newAcc[63] != p[63]);
                else
                    o = c;
            end
            mac_ops_pkg::opMsub, mac_ops_pkg::opMsubu:
            begin
                newAcc = oldAcc - p;
                c = oldAcc < p;       // Borrow
                if (op == mac_ops_pkg::opMsub)
                    o = (oldAcc[63] != p[63]) && (newAcc[63] != oldAcc[63]);
                else
                    o = c;
            end
            mac_ops_pkg::opMthi: newAcc[63:32] = a;
            mac_ops_pkg::opMtlo: newAcc[31:0]  = a;
            default: ;
        endcase
        res = (op == mac_ops_pkg::opMfhi) ? oldAcc[63:32] : newAcc[31:0];
        modelAcc[lane] = newAcc;
        pending.push_back({laneBits'(lane), c, (newAcc == 64'd0), o, newAcc[63], res});
        inFlight[lane]++;
    endtask

    task automatic popResult(input logic [laneBits-1:0] lane);
        int hit;
        hit = -1;
        foreach (pending[i])
            if (hit < 0 && pending[i][entryBits-1 -: laneBits] == lane)
                hit = i;
        if (hit >= 0)
            pending.delete(hit);
        inFlight[lane]--;
    endtask

    // Model follows every transfer seen at the edge
    always @(posedge Clock)
    begin
        if (nReset && InValid && InReady)
            predict(int'(InLane), InOp, InA, InB);
        if (nReset && OutValid)
        begin
            popResult(OutLane);
            owed++;
        end
    end

    always @(negedge Clock)
    begin
        expPresent = 1'b0;
        if (OutValid)
            foreach (pending[i])
                if (!expPresent && pending[i][entryBits-1 -: laneBits] == OutLane)
                begin
                    expPresent = 1'b1;
                    expFlags   = pending[i][35:32];
                    expData    = pending[i][31:0];
                end
    end

    // Consumer frees results after a gap
    initial
    begin
        int gapLeft;
        gapLeft = 0;
        OutCreditReturn = 1'b0;
        forever
        begin
            @(posedge Clock);
            #1;
            OutCreditReturn = 1'b0;
            if (owed > 0 && !holdCredits)
            begin
                if (gapLeft == 0)
                begin
                    OutCreditReturn = 1'b1;
                    owed--;
                    gapLeft = randomGaps ? int'((nextRand() >> 16) % 8) : 0;
                end
                else
                    gapLeft--;
            end
        end
    end

    //----------------------------
    // Checks
    //----------------------------
    assert property (@(posedge Clock) $rose(nReset) |-> (!OutValid && InReady))
        else
        begin
            errors++;
            $display("Outputs not idle after reset");
        end

    assert property (@(posedge Clock) disable iff (!nReset) OutValid |-> expPresent)
        else
        begin
            errors++;
            $display("Result on lane %0d with no operation outstanding", $sampled(OutLane));
        end

    assert property (@(posedge Clock) disable iff (!nReset)
        (OutValid && expPresent) |-> (OutData == expData))
        else
        begin
            errors++;
            $display("CHECK FAILED %s data: expected %h actual %h",
                     testName, $sampled(expData), $sampled(OutData));
        end

    assert property (@(posedge Clock) disable iff (!nReset)
        (OutValid && expPresent) |-> (OutFlags == expFlags))
        else
        begin
            errors++;
            $display("CHECK FAILED %s flags CZON: expected %b actual %b",
                     testName, $sampled(expFlags), $sampled(OutFlags));
        end

    // Consumer never holds more than its credits
    assert property (@(posedge Clock) disable iff (!nReset)
        OutValid |-> (owed < `MAC_OUT_CREDITS))
        else
        begin
            errors++;
            $display("Result sent while the consumer had no free credit");
        end

    assert property (@(posedge Clock) disable iff (!nReset)
        (holdCredits && owed == `MAC_OUT_CREDITS && inFlight[InLane] == `MAC_LANE_DEPTH)
        |-> !InReady)
        else
        begin
            errors++;
            $display("Input ready for lane %0d although it is full", $sampled(InLane));
        end

    //----------------------------
    // Stimulus
    //----------------------------
    task automatic issue(input int lane, input mac_ops_pkg::macOp op,
                         input logic [31:0] a, input logic [31:0] b);
        InValid = 1'b1;
        InLane  = laneBits'(lane);
        InOp    = op;
        InA     = a;
        InB     = b;
        @(posedge Clock);
        while (!InReady)
            @(posedge Clock);  // Stalled caller
        #1;
        InValid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        InLane = '0;
        repeat (cycles) @(posedge Clock);
        #1;
    endtask

    // All results out and every output credit back at the collector
    task automatic drainResults();
        while (pending.size() != 0 || owed != 0)
            @(posedge Clock);
        #1;
    endtask

    initial
    begin
        int r;
        nReset      = 1'b0;
        InValid     = 1'b0;
        InLane      = '0;
        InOp        = mac_ops_pkg::opMult;
        InA         = '0;
        InB         = '0;
        holdCredits = 1'b0;
        randomGaps  = 1'b0;
        seed        = 32'h861a_231a;
        errors      = 0;
        owed        = 0;
        expPresent  = 1'b0;
        testName    = "reset";
        for (int i = 0; i < `MAC_LANES; i++)
        begin
            modelAcc[i] = '0;
            inFlight[i] = 0;
        end
        repeat (2) @(posedge Clock);
        #1;
        nReset = 1'b1;

        for (int i = 0; i < `MAC_LANES; i++)
            issue(i, mac_ops_pkg::opMflo, 32'd0, 32'd0);  // Zero with Z
        drainResults();

        testName = "mult";
        issue(1, mac_ops_pkg::opMult, 32'hffff_fffd, 32'd7);
        issue(1, mac_ops_pkg::opMfhi, 32'd0, 32'd0);
        issue(1, mac_ops_pkg::opMflo, 32'd0, 32'd0);
        issue(1, mac_ops_pkg::opMultu, 32'hffff_fffd, 32'd7);
        issue(1, mac_ops_pkg::opMfhi, 32'd0, 32'd0);
        issue(1, mac_ops_pkg::opMflo, 32'd0, 32'd0);
        issue(1, mac_ops_pkg::opMult, 32'h8000_0000, 32'h8000_0000);
        drainResults();

        // Signed and unsigned boundaries around the accumulator
        testName = "flags";
        issue(2, mac_ops_pkg::opMthi, 32'h7fff_ffff, 32'd0);
        issue(2, mac_ops_pkg::opMtlo, 32'hffff_ffff, 32'd0);
        issue(2, mac_ops_pkg::opMadd, 32'd1, 32'd1);
        issue(2, mac_ops_pkg::opMsub, 32'd1, 32'd1);
        issue(2, mac_ops_pkg::opMthi, 32'd0, 32'd0);
        issue(2, mac_ops_pkg::opMtlo, 32'd0, 32'd0);
        issue(2, mac_ops_pkg::opMsubu, 32'd1, 32'd1);
        issue(2, mac_ops_pkg::opMaddu, 32'd1, 32'd1);
        issue(2, mac_ops_pkg::opMsub, 32'hffff_ffff, 32'd1);
        issue(2, mac_ops_pkg::opMadd, 32'd1, 32'hffff_ffff);
        drainResults();

        testName = "moves";
        issue(3, mac_ops_pkg::opMthi, 32'h1234_5678, 32'd0);
        issue(3, mac_ops_pkg::opMtlo, 32'h9abc_def0, 32'd0);
        issue(3, mac_ops_pkg::opMfhi, 32'd0, 32'd0);
        issue(3, mac_ops_pkg::opMflo, 32'd0, 32'd0);
        issue(0, mac_ops_pkg::opMfhi, 32'd0, 32'd0);  // Other lanes untouched
        issue(0, mac_ops_pkg::opMflo, 32'd0, 32'd0);
        issue(1, mac_ops_pkg::opMfhi, 32'd0, 32'd0);
        drainResults();

        // Fill lanes 0 and 1 with the consumer stalled
        testName = "backpressure";
        holdCredits = 1'b1;
        for (int i = 0; i < 6; i++)
            issue(0, mac_ops_pkg::opMaddu, 32'(i + 1), 32'h0001_0003);
        issue(1, mac_ops_pkg::opMult, 32'hdead_beef, 32'h0000_1234);
        issue(1, mac_ops_pkg::opMflo, 32'd0, 32'd0);
        idle(30);
        holdCredits = 1'b0;
        drainResults();

        testName   = "random";
        randomGaps = 1'b1;
        for (int n = 0; n < numRandom; n++)
        begin
            r = int'((nextRand() >> 16) % 10);
            issue(int'((nextRand() >> 12) % `MAC_LANES), mac_ops_pkg::macOp'(4'(r)),
                  nextRand(), nextRand());
        end
        drainResults();
        idle(10);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Watchdog sized from the operation count
    initial
    begin
        repeat ((numOps + 20) * 16) @(posedge Clock);
        $display("Timeout: run did not finish, %0d results outstanding", pending.size());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
